// ==== Bender.yml ====
package:
  name: radio_ctrl

sources:
  - include_dirs:
      - .
    files:
      - radio_ctrl_pkg.sv
      - cmd_decode.sv
      - radio_ctrl_execute.sv
      - status_result.sv
      - radio_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_radio_ctrl_checker.sv
      - tb_radio_ctrl.sv

// ==== cmd_decode.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module cmd_decode import radio_ctrl_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,

  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  wb_adr_t               wb_adr_i,
  input  logic [`RC_DATA_W-1:0] wb_dat_i,
  output logic                  wb_ack_o,
  output logic [`RC_DATA_W-1:0] wb_dat_o,

  // Toward execute and result
  output cmd_t                  cmd_o,
  output logic                  rd_stb_o,
  input  resp_t                 read_data_i
);

  logic                  accept;
  logic                  held_q;
  logic                  ack_q;
  logic                  cmd_valid_q;
  logic                  rd_stb_q;
  logic [`RC_ADDR_W-1:0] addr_q;
  logic                  ptt_q;
  logic                  resp_req_q;
  cmd_word_u             data_q;
  logic [`RC_DATA_W-1:0] rd_data_q;

  // New cycle only once the previous strobe has gone away
  assign accept = wb_cyc_i & wb_stb_i & ~held_q;

  ////////////////////
  // Handshake

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q      <= 1'b0;
      ack_q       <= 1'b0;
      cmd_valid_q <= 1'b0;
      rd_stb_q    <= 1'b0;
    end else begin
      // Stays set while the master still holds stb
      held_q      <= accept | (held_q & wb_stb_i);
      ack_q       <= accept;
      cmd_valid_q <= accept & wb_we_i;
      rd_stb_q    <= accept & ~wb_we_i;
    end
  end

  ////////////////////
  // Command and read capture

  always_ff @(posedge clk_ctrl) begin
    if (accept && wb_we_i) begin
      addr_q     <= wb_adr_i.addr;
      ptt_q      <= wb_adr_i.ptt;
      resp_req_q <= wb_adr_i.resp_req;
      data_q     <= wb_dat_i;
    end
    if (accept && !wb_we_i) begin
      rd_data_q <= read_data_i;
    end
  end

  always_comb begin
    cmd_o          = '0;
    cmd_o.valid    = cmd_valid_q;
    cmd_o.addr     = addr_q;
    cmd_o.ptt      = ptt_q;
    cmd_o.resp_req = resp_req_q;
    cmd_o.data     = data_q;
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rd_data_q;
  assign rd_stb_o = rd_stb_q;

  // One ack per bus cycle
  a_ack_single: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== radio_ctrl_execute.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module radio_ctrl_execute import radio_ctrl_pkg::*; (
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  cmd_t       cmd_i,

  // Front end and PA
  output logic [3:0] leds_o,
  output logic       rffe_rfsw_sel_o,
  output logic [7:0] drive_level_o,
  output logic       pa_en_o,
  output logic       tx_on_o,
  output logic       pa_tr_o,
  output logic       tx_active_o
);

  localparam int unsigned WD_W = $clog2(`RC_TX_TIMEOUT + 1);
  localparam logic [WD_W-1:0] WD_LIMIT = WD_W'(`RC_TX_TIMEOUT);

  logic [3:0]      leds_q;
  logic            rfsw_q;
  logic [7:0]      drive_q;
  logic            pa_en_q;
  logic            ptt_q;
  logic [WD_W-1:0] wd_cnt_q;
  logic            wd_expired;
  logic            pa_tr_q;

  ////////////////////
  // Command registers

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      leds_q  <= '0;
      rfsw_q  <= 1'b0;
      drive_q <= '0;
      pa_en_q <= 1'b0;
      ptt_q   <= 1'b0;
    end else if (cmd_i.valid) begin
      // PTT rides on every command, whatever the address
      ptt_q <= cmd_i.ptt;
      if (cmd_i.addr == `RC_ADDR_CONFIG) begin
        leds_q <= cmd_i.data.cfg.leds;
        rfsw_q <= cmd_i.data.cfg.rfsw_sel;
      end
      if (cmd_i.addr == `RC_ADDR_TX) begin
        drive_q <= cmd_i.data.tx.drive_level;
        pa_en_q <= cmd_i.data.tx.pa_enable;
      end
    end
  end

  ////////////////////
  // Transmit watchdog

  // Counts up from the last command, parks at the limit
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wd_cnt_q <= '0;
    end else if (cmd_i.valid) begin
      wd_cnt_q <= '0;
    end else if (wd_cnt_q != WD_LIMIT) begin
      wd_cnt_q <= wd_cnt_q + 1'b1;
    end
  end

  assign wd_expired = (wd_cnt_q == WD_LIMIT);

  ////////////////////
  // Keying

  assign tx_on_o = ptt_q & pa_en_q & ~wd_expired;

  // T/R relay follows one cycle behind
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pa_tr_q <= 1'b0;
    end else begin
      pa_tr_q <= tx_on_o;
    end
  end

  assign leds_o          = leds_q;
  assign rffe_rfsw_sel_o = rfsw_q;
  assign drive_level_o   = drive_q;
  assign pa_en_o         = pa_en_q;
  assign pa_tr_o         = pa_tr_q;
  assign tx_active_o     = tx_on_o;

  // Keying only starts from a command and with the PA enabled
  a_tx_rise: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $rose(tx_on_o) |-> pa_en_o && $past(cmd_i.valid));

endmodule

// ==== radio_ctrl_params.svh ====
`ifndef RADIO_CTRL_PARAMS_SVH
`define RADIO_CTRL_PARAMS_SVH

////////////////////
// Command format

// Width of the command address field
`define RC_ADDR_W 6

// Width of the command word
`define RC_DATA_W 32

////////////////////
// Command addresses

`define RC_ADDR_CONFIG 6'h00
`define RC_ADDR_TX 6'h09

////////////////////
// Timing

// Transmit watchdog, in clk_ctrl cycles
`define RC_TX_TIMEOUT 2000
`define RC_SYNC_STAGES 2

`endif

// ==== radio_ctrl_pkg.sv ====
`include "radio_ctrl_params.svh"

package radio_ctrl_pkg;

  ////////////////////
  // Bus address

  // Command address in the low bits, flags above it
  typedef struct packed {
    logic                  resp_req;
    logic                  ptt;
    logic [`RC_ADDR_W-1:0] addr;
  } wb_adr_t;

  ////////////////////
  // Command word views

  // Word at the configuration address
  typedef struct packed {
    logic [`RC_DATA_W-6:0] reserved;
    logic                  rfsw_sel;
    logic [3:0]            leds;
  } config_word_t;

  // Word at the transmit address
  typedef struct packed {
    logic [`RC_DATA_W-10:0] reserved;
    logic                   pa_enable;
    logic [7:0]             drive_level;
  } tx_word_t;

  // The command address picks the view
  typedef union packed {
    config_word_t cfg;
    tx_word_t     tx;
  } cmd_word_u;

  typedef struct packed {
    logic                  valid;
    logic [`RC_ADDR_W-1:0] addr;
    logic                  ptt;
    logic                  resp_req;
    cmd_word_u             data;
  } cmd_t;

  ////////////////////
  // Response word

  typedef struct packed {
    logic [14:0]           reserved;
    logic [7:0]            cmd_count;
    logic                  rxgoodlvl_seen;
    logic                  rxclip_seen;
    logic                  tx_active;
    logic [`RC_ADDR_W-1:0] last_addr;
  } resp_t;

endpackage

// ==== radio_ctrl_top.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module radio_ctrl_top import radio_ctrl_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,

  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  wb_adr_t               wb_adr_i,
  input  logic [`RC_DATA_W-1:0] wb_dat_i,
  output logic [`RC_DATA_W-1:0] wb_dat_o,
  output logic                  wb_ack_o,

  // Receive status
  input  logic                  rxclip_i,
  input  logic                  rxgoodlvl_i,

  // Front end, PA and response flag
  output logic [3:0]            leds_o,
  output logic                  rffe_rfsw_sel_o,
  output logic [7:0]            drive_level_o,
  output logic                  pa_en_o,
  output logic                  tx_on_o,
  output logic                  pa_tr_o,
  output logic                  resp_pending_o
);

  cmd_t  cmd;
  logic  rd_stb;
  resp_t read_data;
  logic  tx_active;

  cmd_decode u_decode (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o),
    .cmd_o       (cmd),
    .rd_stb_o    (rd_stb),
    .read_data_i (read_data)
  );

  radio_ctrl_execute u_execute (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .cmd_i           (cmd),
    .leds_o          (leds_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o),
    .drive_level_o   (drive_level_o),
    .pa_en_o         (pa_en_o),
    .tx_on_o         (tx_on_o),
    .pa_tr_o         (pa_tr_o),
    .tx_active_o     (tx_active)
  );

  status_result u_result (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .cmd_i          (cmd),
    .rd_stb_i       (rd_stb),
    .tx_active_i    (tx_active),
    .rxclip_i       (rxclip_i),
    .rxgoodlvl_i    (rxgoodlvl_i),
    .read_data_o    (read_data),
    .resp_pending_o (resp_pending_o)
  );

endmodule

// ==== status_result.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module status_result import radio_ctrl_pkg::*; (
  input  logic  clk_ctrl,
  input  logic  rst_n_i,
  input  cmd_t  cmd_i,
  input  logic  rd_stb_i,
  input  logic  tx_active_i,

  // Receive status from the converter
  input  logic  rxclip_i,
  input  logic  rxgoodlvl_i,

  output resp_t read_data_o,
  output logic  resp_pending_o
);

  localparam int unsigned S = `RC_SYNC_STAGES;

  logic [S-1:0]          clip_sync_q;
  logic [S-1:0]          good_sync_q;
  logic                  clip_seen_q;
  logic                  good_seen_q;
  logic                  pending_q;
  logic [7:0]            cmd_count_q;
  logic [`RC_ADDR_W-1:0] last_addr_q;

  ////////////////////
  // Synchronizers

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clip_sync_q <= '0;
      good_sync_q <= '0;
    end else begin
      clip_sync_q <= {clip_sync_q[S-2:0], rxclip_i};
      good_sync_q <= {good_sync_q[S-2:0], rxgoodlvl_i};
    end
  end

  ////////////////////
  // Sticky state

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clip_seen_q <= 1'b0;
      good_seen_q <= 1'b0;
      pending_q   <= 1'b0;
      cmd_count_q <= '0;
      last_addr_q <= '0;
    end else begin
      // A new event wins over the read clear
      clip_seen_q <= clip_sync_q[S-1] | (clip_seen_q & ~rd_stb_i);
      good_seen_q <= good_sync_q[S-1] | (good_seen_q & ~rd_stb_i);
      pending_q   <= (cmd_i.valid & cmd_i.resp_req) | (pending_q & ~rd_stb_i);
      if (cmd_i.valid) begin
        cmd_count_q <= cmd_count_q + 1'b1;
        last_addr_q <= cmd_i.addr;
      end
    end
  end

  always_comb begin
    read_data_o                = '0;
    read_data_o.cmd_count      = cmd_count_q;
    read_data_o.rxgoodlvl_seen = good_seen_q;
    read_data_o.rxclip_seen    = clip_seen_q;
    read_data_o.tx_active      = tx_active_i;
    read_data_o.last_addr      = last_addr_q;
  end

  assign resp_pending_o = pending_q;

  a_pending_clear: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $fell(resp_pending_o) |-> $past(rd_stb_i));

endmodule

// ==== tb_radio_ctrl.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module tb_radio_ctrl import radio_ctrl_pkg::*; ();

  localparam int ACK_WAIT = 50;

  logic        clk_ctrl;
  logic        rst_n_i;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  wb_adr_t     wb_adr;
  logic [31:0] wb_dat_w, wb_dat_r;
  logic        rxclip, rxgoodlvl;
  logic [3:0]  leds;
  logic [7:0]  drive_level;
  logic        rfsw_sel, pa_en, tx_on, pa_tr, resp_pending;
  logic [31:0] lfsr;
  logic        last_ptt;
  int          err_count, check_count, tests_run, errs_at_start;
  int          timeouts;

  radio_ctrl_top u_radio_ctrl_top (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .wb_cyc_i        (wb_cyc),
    .wb_stb_i        (wb_stb),
    .wb_we_i         (wb_we),
    .wb_adr_i        (wb_adr),
    .wb_dat_i        (wb_dat_w),
    .wb_dat_o        (wb_dat_r),
    .wb_ack_o        (wb_ack),
    .rxclip_i        (rxclip),
    .rxgoodlvl_i     (rxgoodlvl),
    .leds_o          (leds),
    .rffe_rfsw_sel_o (rfsw_sel),
    .drive_level_o   (drive_level),
    .pa_en_o         (pa_en),
    .tx_on_o         (tx_on),
    .pa_tr_o         (pa_tr),
    .resp_pending_o  (resp_pending)
  );

  tb_radio_ctrl_checker u_checker (
    .clk_ctrl (clk_ctrl), .rst_n_i (rst_n_i),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_ack_i (wb_ack),
    .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_rd_dat_i (wb_dat_r),
    .rxclip_i (rxclip), .rxgoodlvl_i (rxgoodlvl), .leds_i (leds),
    .drive_level_i (drive_level), .rfsw_sel_i (rfsw_sel), .pa_en_i (pa_en),
    .tx_on_i (tx_on), .pa_tr_i (pa_tr), .resp_pending_i (resp_pending),
    .error_count_o (err_count), .check_count_o (check_count)
  );

  always #5 clk_ctrl = ~clk_ctrl;

  ////////////////////
  // Random source

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Mostly the two live addresses
  function automatic logic [5:0] pick_addr();
    logic [31:0] sel;
    sel = rand_bits(2);
    if (sel == 0)
      return 6'(rand_bits(6));
    if (sel == 1)
      return `RC_ADDR_CONFIG;
    return `RC_ADDR_TX;
  endfunction

  ////////////////////
  // Bus driver

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic bus_cycle(input logic we, input wb_adr_t adr, input logic [31:0] dat);
    int waited;
    @(negedge clk_ctrl);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    do begin
      @(negedge clk_ctrl);
      waited++;
    end while (!wb_ack && waited < ACK_WAIT);
    if (!wb_ack)
      report_timeout("no Wishbone ack within 50 cycles");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_cmd(input logic [5:0] addr, input logic ptt, input logic resp_req,
                           input logic [31:0] dat);
    wb_adr_t adr;
    adr.addr     = addr;
    adr.ptt      = ptt;
    adr.resp_req = resp_req;
    last_ptt     = ptt;
    bus_cycle(1'b1, adr, dat);
  endtask

  task automatic write_random(input logic resp_req);
    logic [5:0]  addr;
    logic [31:0] ptt;
    logic [31:0] dat;
    addr = pick_addr();
    ptt  = rand_bits(1);
    dat  = rand_bits(32);
    write_cmd(addr, ptt[0], resp_req, dat);
  endtask

  // Quiet gap so that status pulses are through the synchronizers
  task automatic read_resp();
    repeat (5) @(negedge clk_ctrl);
    bus_cycle(1'b0, '0, '0);
  endtask

  task automatic pulse_status();
    logic [31:0] r;
    r = rand_bits(2);
    @(negedge clk_ctrl);
    rxclip    = r[0];
    rxgoodlvl = r[1];
    @(negedge clk_ctrl);
    rxclip    = 1'b0;
    rxgoodlvl = 1'b0;
  endtask

  task automatic wait_tx(input logic level, input int limit, input string what);
    int waited;
    waited = 0;
    while (tx_on !== level && waited < limit) begin
      @(negedge clk_ctrl);
      waited++;
    end
    if (tx_on !== level)
      report_timeout(what);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d (%s) finished with %0d errors", tests_run, name,
             err_count + timeouts - errs_at_start);
    errs_at_start = err_count + timeouts;
  endtask

  ////////////////////
  // Test sequence

  initial begin
    logic [5:0]  addr;
    logic [31:0] op;
    clk_ctrl  = 1'b0;
    rst_n_i   = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    rxclip    = 1'b0;
    rxgoodlvl = 1'b0;
    lfsr      = 32'h327f;
    last_ptt  = 1'b0;
    tests_run     = 0;
    errs_at_start = 0;
    timeouts      = 0;
    repeat (16) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    rst_n_i = 1'b1;

    repeat (8) write_cmd(`RC_ADDR_CONFIG, 1'b0, 1'b0, rand_bits(32));
    finish_test("config writes");

    repeat (12) write_random(1'b0);
    finish_test("transmit writes");

    // Same PTT as before so that keying stays put
    repeat (8) begin
      addr = 6'(rand_bits(6));
      if (addr == `RC_ADDR_CONFIG || addr == `RC_ADDR_TX)
        addr = addr ^ 6'h20;
      write_cmd(addr, last_ptt, 1'b0, rand_bits(32));
    end
    read_resp();
    finish_test("other addresses");

    op    = rand_bits(32);
    op[8] = 1'b1;
    write_cmd(`RC_ADDR_TX, 1'b1, 1'b0, op);
    wait_tx(1'b1, 5, "tx_on_o did not rise after a PTT write");
    wait_tx(1'b0, `RC_TX_TIMEOUT + 10, "tx_on_o stayed high past the watchdog time");
    write_cmd(`RC_ADDR_TX, 1'b1, 1'b0, op);
    wait_tx(1'b1, 5, "tx_on_o did not come back after a new PTT write");
    read_resp();
    finish_test("transmit watchdog");

    repeat (6) begin
      write_random(1'b1);
      pulse_status();
      read_resp();
    end
    finish_test("response reads");

    repeat (60) begin
      op = rand_bits(2);
      if (op < 2)
        write_random(op[0]);
      else if (op == 2)
        read_resp();
      else
        pulse_status();
    end
    finish_test("mixed traffic");

    repeat (3) @(negedge clk_ctrl);
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count,
             err_count + timeouts);
    if (err_count + timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tb_radio_ctrl_checker.sv ====
`timescale 1ns/1ps

`include "radio_ctrl_params.svh"

module tb_radio_ctrl_checker import radio_ctrl_pkg::*; (
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_i,
  input  wb_adr_t     wb_adr_i,
  input  logic [31:0] wb_dat_i, wb_rd_dat_i,
  input  logic        rxclip_i, rxgoodlvl_i,
  input  logic [3:0]  leds_i,
  input  logic [7:0]  drive_level_i,
  input  logic        rfsw_sel_i, pa_en_i, tx_on_i, pa_tr_i, resp_pending_i,
  output int          error_count_o,
  output int          check_count_o
);

  localparam int TMO = `RC_TX_TIMEOUT;

  logic [3:0]  m_leds;
  logic [7:0]  m_drive, m_count;
  logic [5:0]  m_last_addr;
  logic        m_rfsw, m_pa_en, m_ptt, m_pending, m_clip, m_good;
  int          since;
  logic        exp_tx, tx_dc, prev_tx, prev_dc;
  logic        req_open, req_we;
  wb_adr_t     req_adr;
  logic [31:0] req_dat;
  resp_t       exp_resp;
  resp_t       dc_mask;

  initial begin
    error_count_o = 0;
    check_count_o = 0;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count_o++;
    if (exp !== act) begin
      error_count_o++;
      $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    end
  endtask

  task automatic report(input string what);
    error_count_o++;
    $display("Bus error at %0t: %s", $time, what);
  endtask

  always @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      {m_leds, m_drive, m_count, m_last_addr} = '0;
      {m_rfsw, m_pa_en, m_ptt, m_pending, m_clip, m_good} = '0;
      since    = 0;
      prev_tx  = 1'b0;
      prev_dc  = 1'b0;
      req_open = 1'b0;
    end else begin
      // Outputs still show the state from before this edge
      exp_tx = m_ptt & m_pa_en & (since < TMO + 2);
      // Watchdog edge may land anywhere in a two cycle window
      tx_dc  = exp_tx & (since >= TMO);
      compare("leds_o", m_leds, leds_i);
      compare("rffe_rfsw_sel_o", m_rfsw, rfsw_sel_i);
      compare("drive_level_o", m_drive, drive_level_i);
      compare("pa_en_o", m_pa_en, pa_en_i);
      compare("resp_pending_o", m_pending, resp_pending_i);
      if (!tx_dc)
        compare("tx_on_o", exp_tx, tx_on_i);
      if (!prev_dc)
        compare("pa_tr_o", prev_tx, pa_tr_i);
      if (since < TMO + 2)
        since++;

      ////////////////////
      // Bus cycles
      if (req_open) begin
        req_open = 1'b0;
        if (!wb_ack_i) begin
          report("the ack did not come one cycle after the request");
        end else if (req_we) begin
          m_ptt       = req_adr.ptt;
          m_count     = m_count + 8'd1;
          m_last_addr = req_adr.addr;
          since       = 0;
          if (req_adr.resp_req)
            m_pending = 1'b1;
          if (req_adr.addr == `RC_ADDR_CONFIG) begin
            m_leds = req_dat[3:0];
            m_rfsw = req_dat[4];
          end
          if (req_adr.addr == `RC_ADDR_TX) begin
            m_drive = req_dat[7:0];
            m_pa_en = req_dat[8];
          end
        end else begin
          // Read data was taken on the edge that saw the request
          exp_resp                = '0;
          exp_resp.cmd_count      = m_count;
          exp_resp.rxgoodlvl_seen = m_good;
          exp_resp.rxclip_seen    = m_clip;
          exp_resp.tx_active      = prev_tx;
          exp_resp.last_addr      = m_last_addr;
          // Tx bit is left out while the watchdog window is open
          dc_mask                 = '0;
          dc_mask.tx_active       = prev_dc;
          compare("wb_dat_o", exp_resp & ~dc_mask, wb_rd_dat_i & ~dc_mask);
          m_pending = 1'b0;
          m_clip    = 1'b0;
          m_good    = 1'b0;
        end
      end else if (wb_ack_i) begin
        report("an ack came without a request");
      end else if (wb_cyc_i && wb_stb_i) begin
        req_open = 1'b1;
        req_we   = wb_we_i;
        req_adr  = wb_adr_i;
        req_dat  = wb_dat_i;
      end

      // A pulse after the read clear still counts
      if (rxclip_i)
        m_clip = 1'b1;
      if (rxgoodlvl_i)
        m_good = 1'b1;
      prev_tx = exp_tx;
      prev_dc = tx_dc;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+.
radio_ctrl_pkg.sv
cmd_decode.sv
radio_ctrl_execute.sv
status_result.sv
radio_ctrl_top.sv
tb_radio_ctrl_checker.sv
tb_radio_ctrl.sv
